// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_decode_stage &&
out=$(./obj_dir/Vtb_decode_stage) ;
printf '%s\n' "$out" ;
printf '%s\n' "$out" | grep -qx "All tests passed" && exit 0 || exit 1

// File: sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int NUM_PAIRS  = 1200;
    localparam int MAX_CYCLES = NUM_PAIRS * 4 + 200;   // up to 3 cycles a pair, plus drain

    logic        aclk;
    logic        aresetn;
    logic        flush;
    logic        fetch_valid;
    fetch_pair_t fetch_pair;
    logic        fetch_ready;
    logic        issue_ready;
    logic        issue_valid;
    id_bundle_t  issue_bundle;

    id_bundle_t exp_q[$];
    int         n_checked;
    int         n_mismatch;
    int         n_other;
    int         full_cycles;
    int         ready_mode;   // 0 mostly ready, 1 long stalls, 2 low, 3 high
    int         cycles;

    decode_stage dut_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_pair   (fetch_pair),
        .fetch_ready  (fetch_ready),
        .issue_ready  (issue_ready),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // expected decode of one slot, straight from the ISA encodings
    function automatic decoded_inst_t decode_slot(input logic [31:0] inst,
                                                  input logic [31:0] pc);
        decoded_inst_t d;
        d      = '0;
        d.inst = inst;
        d.pc   = pc;
        d.rd   = inst[4:0];
        d.rj   = inst[9:5];
        d.rk   = inst[14:10];
        if (inst == 32'h0648_3800) d.uop = uop_ertn;
        else if ((inst & 32'hff00_03e0) == 32'h0400_0000) d.uop = uop_csrrd;
        else if ((inst & 32'hffff_8000) == 32'h0010_0000) d.uop = uop_add;
        else if ((inst & 32'hffff_8000) == 32'h0011_0000) d.uop = uop_sub;
        else if ((inst & 32'hffff_8000) == 32'h0014_8000) d.uop = uop_and;
        else if ((inst & 32'hffff_8000) == 32'h0015_0000) d.uop = uop_or;
        else if ((inst & 32'hffff_8000) == 32'h0015_8000) d.uop = uop_xor;
        else if ((inst & 32'hffff_8000) == 32'h002a_0000) d.uop = uop_break;
        else if ((inst & 32'hffff_8000) == 32'h002b_0000) d.uop = uop_syscall;
        else if ((inst & 32'hffc0_0000) == 32'h0280_0000) d.uop = uop_addi;
        else if ((inst & 32'hffc0_0000) == 32'h2880_0000) d.uop = uop_ld;
        else if ((inst & 32'hffc0_0000) == 32'h2980_0000) d.uop = uop_st;
        else if ((inst & 32'hfe00_0000) == 32'h1400_0000) d.uop = uop_lu12i;
        else if ((inst & 32'hfc00_0000) == 32'h5800_0000) d.uop = uop_beq;
        else d.uop = uop_ine;
        case (d.uop)
            uop_addi, uop_ld, uop_st: d.imm = $signed({inst[21:10], 20'b0}) >>> 20;
            uop_lu12i: d.imm = {inst[24:5], 12'b0};
            uop_beq: d.imm = $signed({inst[25:10], 16'b0}) >>> 14;   // offs16 * 4
            uop_csrrd: d.imm = {18'b0, inst[23:10]};
            default: d.imm = '0;
        endcase
        d.is_alu        = d.uop inside {uop_add, uop_sub, uop_and, uop_or, uop_xor,
                                        uop_addi, uop_lu12i};
        d.is_syscall    = (d.uop == uop_syscall);
        d.is_break      = (d.uop == uop_break);
        d.is_privileged = d.uop inside {uop_csrrd, uop_ertn};
        d.ine           = (d.uop == uop_ine);
        return d;
    endfunction

    function automatic id_bundle_t decode_ref(input fetch_pair_t fp);
        id_bundle_t b;
        b.slot0 = decode_slot(fp.inst0, fp.pc0);
        b.slot1 = decode_slot(fp.inst1, fp.pc1);
        b.excp_flag = 1'b1;
        b.exception = excp_ine;
        if (fp.excp_flag) begin
            b.exception = fp.exception;   // fetch fault wins over ine
            b.badv      = fp.badv;
        end else if (b.slot0.ine) begin
            b.badv = fp.pc0;
        end else if (b.slot1.ine) begin
            b.badv = fp.pc1;
        end else begin
            b.excp_flag = 1'b0;
            b.exception = excp_none;
            b.badv      = '0;
        end
        return b;
    endfunction

    // kinds 0..9 plain ops, 10..13 system ops, 14 random word
    function automatic logic [31:0] make_inst(input int kind);
        logic [31:0] r;
        r = $urandom;
        case (kind)
            0: return 32'h0010_0000 | (r & 32'h0000_7fff);
            1: return 32'h0011_0000 | (r & 32'h0000_7fff);
            2: return 32'h0014_8000 | (r & 32'h0000_7fff);
            3: return 32'h0015_0000 | (r & 32'h0000_7fff);
            4: return 32'h0015_8000 | (r & 32'h0000_7fff);
            5: return 32'h0280_0000 | (r & 32'h003f_ffff);
            6: return 32'h1400_0000 | (r & 32'h01ff_ffff);
            7: return 32'h2880_0000 | (r & 32'h003f_ffff);
            8: return 32'h2980_0000 | (r & 32'h003f_ffff);
            9: return 32'h5800_0000 | (r & 32'h03ff_ffff);
            10: return 32'h002b_0000 | (r & 32'h0000_7fff);
            11: return 32'h002a_0000 | (r & 32'h0000_7fff);
            12: return 32'h0400_0000 | (r & 32'h00ff_fc1f);
            13: return 32'h0648_3800;
            default: return r;
        endcase
    endfunction

    function automatic fetch_pair_t make_pair(input int kmin, input int kmax,
                                              input int adef_pct);
        fetch_pair_t fp;
        fp.inst0     = make_inst($urandom_range(kmax, kmin));
        fp.inst1     = make_inst($urandom_range(kmax, kmin));
        fp.pc0       = $urandom & 32'hffff_fffc;
        fp.pc1       = fp.pc0 + 32'd4;
        fp.excp_flag = ($urandom_range(99, 0) < adef_pct);
        fp.exception = fp.excp_flag ? excp_adef : excp_none;
        fp.badv      = fp.excp_flag ? fp.pc0 : $urandom;   // junk unless faulting
        return fp;
    endfunction

    // one push, with a random idle gap before it
    task automatic send_pair(input fetch_pair_t fp);
        repeat ($urandom_range(2, 0)) @(negedge aclk);
        fetch_pair  = fp;
        fetch_valid = 1'b1;
        while (!fetch_ready) @(negedge aclk);
        @(negedge aclk);
        fetch_valid = 1'b0;
    endtask

    task automatic run_phase(input int n, input int kmin, input int kmax, input int adef_pct);
        repeat (n) send_pair(make_pair(kmin, kmax, adef_pct));
    endtask

    task automatic check_bundle(input id_bundle_t got, input id_bundle_t exp);
        n_checked++;
        if (got.slot0 !== exp.slot0) begin
            n_mismatch++;
            $display("mismatch at %0t: slot0 inst %h uop %0d/%0d imm %h/%h", $time,
                     exp.slot0.inst, got.slot0.uop, exp.slot0.uop, got.slot0.imm, exp.slot0.imm);
        end
        if (got.slot1 !== exp.slot1) begin
            n_mismatch++;
            $display("mismatch at %0t: slot1 inst %h uop %0d/%0d imm %h/%h", $time,
                     exp.slot1.inst, got.slot1.uop, exp.slot1.uop, got.slot1.imm, exp.slot1.imm);
        end
        if ({got.excp_flag, got.exception, got.badv} !==
            {exp.excp_flag, exp.exception, exp.badv}) begin
            n_mismatch++;
            $display("mismatch at %0t: exception %b/%h badv %h, expected %b/%h badv %h", $time,
                     got.excp_flag, got.exception, got.badv, exp.excp_flag, exp.exception,
                     exp.badv);
        end
    endtask

    // scoreboard, everything sampled on the rising edge
    always @(posedge aclk) begin
        if (flush) begin
            exp_q.delete();
        end else if (aresetn) begin
            if (issue_valid && issue_ready) begin
                if (exp_q.size() == 0) begin
                    n_other++;
                    $display("%0t: a bundle was issued with no pair outstanding", $time);
                end else begin
                    check_bundle(issue_bundle, exp_q.pop_front());
                end
            end
            if (fetch_valid && fetch_ready) exp_q.push_back(decode_ref(fetch_pair));
            if (!fetch_ready) full_cycles++;
        end
    end

    initial begin
        int stretch;
        stretch     = 0;
        issue_ready = 1'b0;
        forever begin
            @(negedge aclk);
            if (ready_mode == 0) begin
                issue_ready = ($urandom_range(3, 0) != 0);
            end else if (ready_mode == 1) begin
                if (stretch == 0) begin
                    issue_ready = !issue_ready;
                    stretch     = $urandom_range(30, 12);
                end else begin
                    stretch--;
                end
            end else begin
                issue_ready = (ready_mode == 3);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h6149));
        aresetn     = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pair  = '0;
        ready_mode  = 0;
        n_checked   = 0;
        n_mismatch  = 0;
        n_other     = 0;
        full_cycles = 0;
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        if (issue_valid !== 1'b0 || fetch_ready !== 1'b1) begin
            n_mismatch++;
            $display("mismatch at %0t: after reset issue_valid %b fetch_ready %b", $time,
                     issue_valid, fetch_ready);
        end
        run_phase(400, 0, 9, 0);
        run_phase(300, 10, 14, 25);   // system ops, unknown words, fetch faults
        ready_mode  = 1;
        full_cycles = 0;
        run_phase(300, 0, 14, 10);
        if (full_cycles == 0) begin
            n_other++;
            $display("%0t: fetch_ready never dropped under back-pressure", $time);
        end
        // empty the pipe after the stalls, then refill it for the flush
        ready_mode = 3;
        while (exp_q.size() != 0 || issue_valid) @(negedge aclk);
        // flush with the queue and the stage register both occupied
        ready_mode = 2;
        run_phase(6, 0, 14, 0);
        flush = 1'b1;
        @(negedge aclk);
        flush = 1'b0;
        if (issue_valid !== 1'b0) begin
            n_mismatch++;
            $display("mismatch at %0t: after flush issue_valid %b", $time, issue_valid);
        end
        ready_mode = 0;
        run_phase(200, 0, 14, 10);
        ready_mode = 3;
        while (exp_q.size() != 0 || issue_valid) @(negedge aclk);
        $display("checked %0d bundles: %0d mismatches, %0d other errors", n_checked,
                 n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0 && n_checked > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: source/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// instruction word and address width
`define INST_WIDTH      32
`define REG_ADDR_WIDTH  5
`define EXCP_WIDTH      7   // matches the estat ecode field

// instruction queue, counted in fetch pairs
`define FIFO_DEPTH      8
`define FIFO_PTR_WIDTH  3   // log2 of FIFO_DEPTH

`endif

// File: source/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

    typedef enum logic [4:0] {
        uop_nop,
        uop_add,
        uop_sub,
        uop_and,
        uop_or,
        uop_xor,
        uop_addi,
        uop_lu12i,
        uop_ld,
        uop_st,
        uop_beq,
        uop_syscall,
        uop_break,
        uop_csrrd,
        uop_ertn,
        uop_ine
    } uop_e;

    typedef enum logic [`EXCP_WIDTH-1:0] {
        excp_none = 7'h00,
        excp_adef = 7'h08,  // fetch address error
        excp_ine  = 7'h0d   // instruction not exist
    } excp_e;

    typedef struct packed {
        logic [`INST_WIDTH-1:0] inst0;
        logic [`INST_WIDTH-1:0] inst1;
        logic [`INST_WIDTH-1:0] pc0;
        logic [`INST_WIDTH-1:0] pc1;
        logic [`INST_WIDTH-1:0] badv;
        logic                   excp_flag;
        excp_e                  exception;
    } fetch_pair_t;

    typedef struct packed {
        logic [`INST_WIDTH-1:0]     inst;
        logic [`INST_WIDTH-1:0]     pc;
        uop_e                       uop;
        logic [`INST_WIDTH-1:0]     imm;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rj;
        logic [`REG_ADDR_WIDTH-1:0] rk;
        logic                       is_alu;
        logic                       is_syscall;
        logic                       is_break;
        logic                       is_privileged;
        logic                       ine;
    } decoded_inst_t;

    typedef struct packed {
        decoded_inst_t          slot0;
        decoded_inst_t          slot1;
        logic [`INST_WIDTH-1:0] badv;
        logic                   excp_flag;
        excp_e                  exception;
    } id_bundle_t;

endpackage

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        flush,
    input  logic        fetch_valid,
    input  fetch_pair_t fetch_pair,
    output logic        fetch_ready,
    input  logic        issue_ready,
    output logic        issue_valid,
    output id_bundle_t  issue_bundle
);

    fetch_pair_t   head;
    logic          head_valid;
    logic          id_ready;
    logic          fifo_pop;
    decoded_inst_t dec0;
    decoded_inst_t dec1;
    id_bundle_t    id_bundle;

    assign fifo_pop = head_valid && id_ready;

    inst_fifo fifo_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .flush      (flush),
        .push_valid (fetch_valid),
        .push_data  (fetch_pair),
        .push_ready (fetch_ready),
        .pop        (fifo_pop),
        .head_valid (head_valid),
        .head       (head)
    );

    inst_decoder dec0_i (
        .inst (head.inst0),
        .pc   (head.pc0),
        .dec  (dec0)
    );

    inst_decoder dec1_i (
        .inst (head.inst1),
        .pc   (head.pc1),
        .dec  (dec1)
    );

    // fetch exception wins, then ine of slot 0, then slot 1
    always_comb begin
        id_bundle.slot0     = dec0;
        id_bundle.slot1     = dec1;
        id_bundle.badv      = head.badv;
        id_bundle.excp_flag = head.excp_flag;
        id_bundle.exception = head.exception;
        if (!head.excp_flag) begin
            if (dec0.ine) begin
                id_bundle.excp_flag = 1'b1;
                id_bundle.exception = excp_ine;
                id_bundle.badv      = dec0.pc;
            end else if (dec1.ine) begin
                id_bundle.excp_flag = 1'b1;
                id_bundle.exception = excp_ine;
                id_bundle.badv      = dec1.pc;
            end else begin
                id_bundle.excp_flag = 1'b0;
                id_bundle.exception = excp_none;
                id_bundle.badv      = '0;
            end
        end
    end

    id_reg id_reg_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .flush        (flush),
        .id_valid     (head_valid),
        .id_bundle    (id_bundle),
        .id_ready     (id_ready),
        .issue_ready  (issue_ready),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle)
    );

endmodule

// File: source/id_reg.sv
`timescale 1ns/1ps

module id_reg import decode_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       flush,
    input  logic       id_valid,
    input  id_bundle_t id_bundle,
    output logic       id_ready,
    input  logic       issue_ready,
    output logic       issue_valid,
    output id_bundle_t issue_bundle
);

    logic load;

    // empty, or the current bundle leaves this cycle
    assign id_ready = issue_ready || !issue_valid;
    assign load     = id_valid && id_ready && !flush;

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            issue_valid <= 1'b0;
        end else if (id_ready) begin
            issue_valid <= id_valid;
        end
    end

    // payload only moves on a load
    always_ff @(posedge aclk) begin
        if (load) begin
            issue_bundle <= id_bundle;
        end
    end

    // a stalled bundle stays put and stays valid
    a_stall_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        issue_valid && !issue_ready && !flush |=> issue_valid && $stable(issue_bundle)
    ) else $error("id_reg: bundle changed while stalled");

endmodule

// File: source/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module inst_decoder import decode_pkg::*; (
    input  logic [`INST_WIDTH-1:0] inst,
    input  logic [`INST_WIDTH-1:0] pc,
    output decoded_inst_t          dec
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [7:0]  op8;
    logic [6:0]  op7;
    logic [5:0]  op6;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op8  = inst[31:24];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];

    always_comb begin
        dec               = '0;
        dec.inst          = inst;
        dec.pc            = pc;
        dec.rd            = inst[4:0];
        dec.rj            = inst[9:5];
        dec.rk            = inst[14:10];

        // opcode match, exact words first
        case (1'b1)
            inst == 32'h0648_3800:            dec.uop = uop_ertn;
            op8 == 8'h04 && inst[9:5] == '0:  dec.uop = uop_csrrd;   // rj=0 selects csrrd
            op17 == 17'h00020:                dec.uop = uop_add;
            op17 == 17'h00022:                dec.uop = uop_sub;
            op17 == 17'h00029:                dec.uop = uop_and;
            op17 == 17'h0002a:                dec.uop = uop_or;
            op17 == 17'h0002b:                dec.uop = uop_xor;
            op17 == 17'h00054:                dec.uop = uop_break;
            op17 == 17'h00056:                dec.uop = uop_syscall;
            op10 == 10'h00a:                  dec.uop = uop_addi;
            op10 == 10'h0a2:                  dec.uop = uop_ld;
            op10 == 10'h0a6:                  dec.uop = uop_st;
            op7 == 7'h0a:                     dec.uop = uop_lu12i;
            op6 == 6'h16:                     dec.uop = uop_beq;
            default:                          dec.uop = uop_ine;
        endcase

        // immediate and class flags per micro-op
        case (dec.uop)
            uop_add, uop_sub, uop_and, uop_or, uop_xor: begin
                dec.is_alu = 1'b1;
            end
            uop_addi: begin
                dec.is_alu = 1'b1;
                dec.imm    = {{20{inst[21]}}, inst[21:10]};   // si12
            end
            uop_lu12i: begin
                dec.is_alu = 1'b1;
                dec.imm    = {inst[24:5], 12'b0};
            end
            uop_ld, uop_st: begin
                dec.imm = {{20{inst[21]}}, inst[21:10]};
            end
            uop_beq: begin
                dec.imm = {{14{inst[25]}}, inst[25:10], 2'b00};   // offs16 << 2
            end
            uop_syscall: begin
                dec.is_syscall = 1'b1;
            end
            uop_break: begin
                dec.is_break = 1'b1;
            end
            uop_csrrd: begin
                dec.is_privileged = 1'b1;
                dec.imm           = {18'b0, inst[23:10]};   // csr number
            end
            uop_ertn: begin
                dec.is_privileged = 1'b1;
            end
            default: begin
                dec.ine = 1'b1;
            end
        endcase
    end

endmodule

// File: source/inst_fifo.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module inst_fifo import decode_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        flush,
    input  logic        push_valid,
    input  fetch_pair_t push_data,
    output logic        push_ready,
    input  logic        pop,
    output logic        head_valid,
    output fetch_pair_t head
);

    localparam logic [`FIFO_PTR_WIDTH:0] DEPTH = `FIFO_DEPTH;

    fetch_pair_t                mem [`FIFO_DEPTH];
    logic [`FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [`FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [`FIFO_PTR_WIDTH:0]   count;
    logic                       do_push;
    logic                       do_pop;

    assign push_ready = (count != DEPTH) && !flush;   // nothing accepted while flushing
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop && head_valid && !flush;

    // pair storage, written at the tail
    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // a full queue stays full until something leaves or a flush
    a_no_overflow: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (count == DEPTH) && !do_pop && !flush |=> (count == DEPTH)
    ) else $error("inst_fifo: entry written into a full queue");

    // the pop request comes from the stage register handshake
    a_no_underflow: assert property (
        @(posedge aclk) disable iff (!aresetn)
        pop |-> head_valid
    ) else $error("inst_fifo: pop while empty");

endmodule

// File: verilog.f
+incdir+source
source/decode_pkg.sv
source/inst_fifo.sv
source/inst_decoder.sv
source/id_reg.sv
source/decode_stage.sv
sim/tb_decode_stage.sv
